/* design/pf_fetch.sv */
module pf_fetch import pf_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            mem_fetch_start_i,  // line fetch begins
    input  logic            end_of_line_i,
    input  logic            end_of_frame_i,
    input  word_t           vram_data_i,        // word at last cycle's address
    input  addr_t           pf_start_addr_i,    // frame start address
    input  word_t           pf_line_len_i,      // words added per display line
    input  bpp_depth_t      pf_bpp_i,
    input  logic [1:0]      pf_v_repeat_i,      // extra showings of each line
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    pf_words_if.fetcher     words
);

    fetch_state_t   state;
    fetch_state_t   state_next;
    logic           issue;                      // put pf_addr on the bus this cycle
    addr_t          pf_addr;                    // next display word to read
    addr_t          line_start;                 // first word of current display line
    logic [1:0]     v_count;                    // vertical repeat countdown
    logic [1:0]     grp_count;                  // groups issued this line, saturates at 2
    logic           ready_q;

    // next state and read issue decode
    always_comb begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            FETCH_IDLE: begin
                state_next = FETCH_IDLE;
            end
            FETCH_ADDR: begin
                // group 0 is picked up at scan-out start, so it never waits
                if (!words.buf_full || grp_count == 2'd0) begin
                    issue      = 1'b1;
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                issue      = (pf_bpp_i != BPP_1_ATTR);      // word 1 address
                state_next = FETCH_READ_0;
            end
            FETCH_READ_0: begin
                if (pf_bpp_i == BPP_1_ATTR) begin
                    state_next = FETCH_ADDR;                // single word group
                end else begin
                    issue      = (pf_bpp_i != BPP_4);       // word 2 address
                    state_next = FETCH_READ_1;
                end
            end
            FETCH_READ_1: begin
                if (pf_bpp_i == BPP_4) begin
                    state_next = FETCH_ADDR;
                end else begin
                    issue      = 1'b1;                      // word 3 address
                    state_next = FETCH_READ_2;
                end
            end
            FETCH_READ_2: state_next = FETCH_READ_3;
            FETCH_READ_3: state_next = FETCH_ADDR;
            default:      state_next = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= FETCH_IDLE;
            vram_sel_o  <= 1'b0;
            vram_addr_o <= '0;
            pf_addr     <= '0;
            line_start  <= '0;
            v_count     <= '0;
            grp_count   <= '0;
            ready_q     <= 1'b0;
        end else begin
            state      <= state_next;
            vram_sel_o <= issue;
            ready_q    <= 1'b0;
            if (issue) begin
                vram_addr_o <= pf_addr;
                pf_addr     <= pf_addr + 1'b1;
            end
            if (issue && state == FETCH_ADDR) begin
                ready_q <= (grp_count == 2'd2);         // strobe previous group from group 2 on
                if (grp_count != 2'd2) begin
                    grp_count <= grp_count + 1'b1;
                end
            end

            if (mem_fetch_start_i) begin
                state     <= FETCH_ADDR;
                pf_addr   <= line_start;
                grp_count <= '0;
            end

            if (end_of_line_i) begin
                state      <= FETCH_IDLE;
                vram_sel_o <= 1'b0;                     // drop any read in flight
                pf_addr    <= line_start;
                if (v_count != 2'd0) begin
                    v_count <= v_count - 1'b1;          // show same row again
                end else begin
                    v_count    <= pf_v_repeat_i;
                    line_start <= line_start + pf_line_len_i;
                end
            end

            if (end_of_frame_i) begin
                pf_addr    <= pf_start_addr_i;
                line_start <= pf_start_addr_i;
                v_count    <= pf_v_repeat_i;
            end
        end
    end

    // words captured one cycle behind each address
    always_ff @(posedge clk) begin
        case (state)
            FETCH_READ_0: begin
                words.data_word0 <= vram_data_i;
                words.attr_word  <= vram_data_i;        // 1 bpp word doubles as attribute
            end
            FETCH_READ_1: words.data_word1 <= vram_data_i;
            FETCH_READ_2: words.data_word2 <= vram_data_i;
            FETCH_READ_3: words.data_word3 <= vram_data_i;
            default: ;
        endcase
    end

    assign words.words_ready = ready_q;

    // registered select must be cleared by the time the FSM idles
    a_no_sel_idle: assert property (@(posedge clk) disable iff (reset_i)
        state == FETCH_IDLE |-> !vram_sel_o);

    // a strobe never lands on a shifter buffer that is still full
    a_ready_room: assert property (@(posedge clk) disable iff (reset_i)
        words.words_ready |-> !words.buf_full);

endmodule

/* design/pf_hscan.sv */
module pf_hscan import pf_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        mem_fetch_i,        // line has display fetch
    input  logic        end_of_line_i,
    input  hres_t       h_count_i,
    input  hres_t       vid_left_i,         // leftmost visible pixel
    input  hres_t       vid_right_i,        // right edge +1
    input  logic [1:0]  pf_h_repeat_i,      // extra cycles per pixel
    output logic        scan_active_o,
    output logic        load_first_o,
    output logic        advance_o
);

    hres_t          start_hcount;           // latched scan-out begin
    hres_t          end_hcount;             // latched scan-out end
    logic           scan_q;
    logic [1:0]     h_count_rep;            // horizontal repeat countdown
    logic           scan_end;

    assign load_first_o  = (h_count_i == start_hcount) && mem_fetch_i;
    assign scan_end      = (h_count_i >= end_hcount);
    // drops in the end cycle so border shows right after
    assign scan_active_o = scan_q && !scan_end && !end_of_line_i;
    assign advance_o     = scan_active_o && (h_count_rep == 2'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_hcount <= H_SCANOUT_BEGIN;
            end_hcount   <= H_SCANOUT_BEGIN;
            scan_q       <= 1'b0;
            h_count_rep  <= '0;
        end else begin
            if (scan_active_o) begin
                if (h_count_rep == 2'd0) begin
                    h_count_rep <= pf_h_repeat_i;   // wrap to the next pixel
                end else begin
                    h_count_rep <= h_count_rep - 1'b1;
                end
            end else begin
                scan_q <= 1'b0;
            end
            if (load_first_o) begin
                scan_q      <= 1'b1;
                h_count_rep <= pf_h_repeat_i;
            end
            if (end_of_line_i) begin
                scan_q       <= 1'b0;
                start_hcount <= H_SCANOUT_BEGIN + vid_left_i;   // edges take effect next line
                end_hcount   <= H_SCANOUT_BEGIN + vid_right_i;
            end
        end
    end

    // pixel steps fall strictly inside the latched window
    a_adv_window: assert property (@(posedge clk) disable iff (reset_i)
        advance_o |-> (h_count_i > start_hcount) && (h_count_i < end_hcount));

endmodule

/* design/pf_pixel_shift.sv */
module pf_pixel_shift import pf_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        scan_active_i,
    input  logic        load_first_i,       // scan-out start
    input  logic        advance_i,          // step to next pixel
    input  bpp_depth_t  pf_bpp_i,
    input  color_t      border_color_i,
    input  color_t      pf_colorbase_i,     // XORed onto every index
    output color_t      pf_color_index_o,
    pf_words_if.shifter words
);

    logic [63:0]    pix_buf;                // next 8 pixels
    logic [63:0]    pixels;                 // pixels shifting out, MSB byte shown
    logic           buf_full_q;
    logic [2:0]     col;                    // pixel column within group
    logic           was_active;

    // expand one fetch group into 8 indices, first pixel in top byte
    function automatic logic [63:0] expand(input bpp_depth_t bpp, input word_t attr,
                                           input word_t w0, input word_t w1,
                                           input word_t w2, input word_t w3);
        logic [63:0] px;
        px = '0;
        case (bpp)
            BPP_1_ATTR: begin
                for (int i = 0; i < PIXELS_PER_GROUP; i++) begin
                    px[63-8*i -: 8] = {4'h0, w0[7-i] ? attr[ATTR_FORE_LSB +: 4]
                                                     : attr[ATTR_BACK_LSB +: 4]};
                end
            end
            BPP_4: begin
                for (int i = 0; i < 4; i++) begin
                    px[63-8*i -: 8]  = {4'h0, w0[15-4*i -: 4]};
                    px[31-8*i -: 8]  = {4'h0, w1[15-4*i -: 4]};
                end
            end
            default: px = {w0, w1, w2, w3};     // 8 bpp, high byte first
        endcase
        return px;
    endfunction

    always_ff @(posedge clk) begin
        if (words.words_ready) begin
            pix_buf <= expand(pf_bpp_i, words.attr_word, words.data_word0,
                              words.data_word1, words.data_word2, words.data_word3);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pixels     <= '0;
            buf_full_q <= 1'b0;
            col        <= '0;
            was_active <= 1'b0;
        end else begin
            was_active <= scan_active_i;
            if (words.words_ready || !scan_active_i) begin
                buf_full_q <= 1'b1;             // outside scan-out this holds off the fetcher
            end
            if (advance_i) begin
                col <= col + 1'b1;
                if (col == 3'(PIXELS_PER_GROUP - 1)) begin
                    pixels     <= pix_buf;      // eighth step, next group
                    buf_full_q <= 1'b0;
                end else begin
                    pixels <= {pixels[55:0], border_color_i};
                end
            end
            if (load_first_i) begin
                // group 0 straight from the fetched words
                pixels     <= expand(pf_bpp_i, words.attr_word, words.data_word0,
                                     words.data_word1, words.data_word2, words.data_word3);
                col        <= '0;
                buf_full_q <= 1'b0;
            end
            if (was_active && !scan_active_i) begin
                pixels[63:56] <= border_color_i;    // scan-out over
            end
        end
    end

    // lets group 1 issue in the start cycle itself
    assign words.buf_full   = buf_full_q && !load_first_i;
    assign pf_color_index_o = pixels[63:56] ^ pf_colorbase_i;

    // fetcher never overruns a buffer still waiting for its eighth step
    a_no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        words.words_ready && scan_active_i |-> !buf_full_q);

endmodule

/* design/pf_pkg.sv */
package pf_pkg;

    localparam int WORD_W           = 16;   // video RAM data width
    localparam int ADDR_W           = 16;   // video RAM word address width
    localparam int COLOR_W          = 8;    // colour index width
    localparam int HRES_W           = 11;   // horizontal counter width

    localparam int OFFSCREEN_WIDTH  = 160;  // h counts ahead of visible pixel 0
    localparam int PIXELS_PER_GROUP = 8;    // pixels per fetch group

    localparam int ATTR_BACK_LSB    = 12;   // background nibble in attribute word
    localparam int ATTR_FORE_LSB    = 8;    // foreground nibble in attribute word

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [HRES_W-1:0]  hres_t;

    // h count where scan-out of pixel 0 begins (two cycles of pipeline ahead)
    localparam hres_t H_SCANOUT_BEGIN = hres_t'(OFFSCREEN_WIDTH - 2);

    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'b00,                 // 1 word per group, fg/bg from attribute
        BPP_4      = 2'b01,                 // 2 words per group
        BPP_8      = 2'b10,                 // 4 words per group
        BPP_XX     = 2'b11                  // decoded as 8 bpp
    } bpp_depth_t;

    typedef enum logic [2:0] {
        FETCH_IDLE   = 3'd0,                // waiting for line fetch start
        FETCH_ADDR   = 3'd1,                // first address out, stalls on full buffer
        FETCH_WAIT   = 3'd2,                // second address out, RAM latency
        FETCH_READ_0 = 3'd3,                // word 0 in (attr too)
        FETCH_READ_1 = 3'd4,                // word 1 in
        FETCH_READ_2 = 3'd5,                // word 2 in
        FETCH_READ_3 = 3'd6                 // word 3 in
    } fetch_state_t;

endpackage

/* design/pf_words_if.sv */
interface pf_words_if import pf_pkg::*; ();

    logic   words_ready;                    // one cycle strobe, previous group complete
    word_t  attr_word;                      // attribute word (1 bpp only)
    word_t  data_word0;
    word_t  data_word1;
    word_t  data_word2;
    word_t  data_word3;
    logic   buf_full;                       // shifter buffer holds unused pixels

    modport fetcher (
        output words_ready,
        output attr_word,
        output data_word0,
        output data_word1,
        output data_word2,
        output data_word3,
        input  buf_full
    );

    modport shifter (
        input  words_ready,
        input  attr_word,
        input  data_word0,
        input  data_word1,
        input  data_word2,
        input  data_word3,
        output buf_full
    );

endinterface

/* design/video_playfield.sv */
module video_playfield import pf_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    // video timing
    input  hres_t       h_count_i,
    input  logic        mem_fetch_i,
    input  logic        mem_fetch_start_i,
    input  logic        end_of_line_i,
    input  logic        end_of_frame_i,
    input  color_t      border_color_i,
    input  hres_t       vid_left_i,
    input  hres_t       vid_right_i,
    // playfield controls
    input  addr_t       pf_start_addr_i,
    input  word_t       pf_line_len_i,
    input  color_t      pf_colorbase_i,
    input  bpp_depth_t  pf_bpp_i,
    input  logic [1:0]  pf_h_repeat_i,
    input  logic [1:0]  pf_v_repeat_i,
    // video RAM
    output logic        vram_sel_o,
    output addr_t       vram_addr_o,
    input  word_t       vram_data_i,
    output color_t      pf_color_index_o
);

    logic   scan_active;
    logic   load_first;
    logic   advance;

    pf_words_if words_if_i ();

    pf_fetch pf_fetch_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .end_of_line_i     (end_of_line_i),
        .end_of_frame_i    (end_of_frame_i),
        .vram_data_i       (vram_data_i),
        .pf_start_addr_i   (pf_start_addr_i),
        .pf_line_len_i     (pf_line_len_i),
        .pf_bpp_i          (pf_bpp_i),
        .pf_v_repeat_i     (pf_v_repeat_i),
        .vram_sel_o        (vram_sel_o),
        .vram_addr_o       (vram_addr_o),
        .words             (words_if_i.fetcher)
    );

    pf_hscan pf_hscan_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .mem_fetch_i   (mem_fetch_i),
        .end_of_line_i (end_of_line_i),
        .h_count_i     (h_count_i),
        .vid_left_i    (vid_left_i),
        .vid_right_i   (vid_right_i),
        .pf_h_repeat_i (pf_h_repeat_i),
        .scan_active_o (scan_active),
        .load_first_o  (load_first),
        .advance_o     (advance)
    );

    pf_pixel_shift pf_pixel_shift_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .scan_active_i    (scan_active),
        .load_first_i     (load_first),
        .advance_i        (advance),
        .pf_bpp_i         (pf_bpp_i),
        .border_color_i   (border_color_i),
        .pf_colorbase_i   (pf_colorbase_i),
        .pf_color_index_o (pf_color_index_o),
        .words            (words_if_i.shifter)
    );

endmodule

/* filelist.f */
design/pf_pkg.sv
design/pf_words_if.sv
design/pf_fetch.sv
design/pf_hscan.sv
design/pf_pixel_shift.sv
design/video_playfield.sv
verification/pf_checker.sv
verification/tb_video_playfield.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the playfield testbench with Verilator, runs it and scans the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_video_playfield \
    --Mdir "$build_dir" -o sim_tb \
    -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "error: verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "error: simulation exited with status $run_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0

/* verification/pf_checker.sv */
module pf_checker import pf_pkg::*; #(
    parameter int RAM_WORDS = 4096
) (
    input  logic        clk,
    input  logic        reset_i,
    input  int          test_id_i,
    input  hres_t       h_count_i,
    input  logic        mem_fetch_i,
    input  logic        end_of_line_i,
    input  logic        end_of_frame_i,
    input  color_t      border_color_i,
    input  hres_t       vid_left_i,
    input  hres_t       vid_right_i,
    input  addr_t       pf_start_addr_i,
    input  word_t       pf_line_len_i,
    input  color_t      pf_colorbase_i,
    input  bpp_depth_t  pf_bpp_i,
    input  logic [1:0]  pf_h_repeat_i,
    input  logic [1:0]  pf_v_repeat_i,
    input  logic        vram_sel_i,
    input  color_t      pf_color_index_i,
    input  word_t       ram_i [RAM_WORDS],   // video RAM contents
    output int          error_count_o,
    output int          check_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    hres_t      scan_begin;                 // window edges as latched at line end
    hres_t      scan_end;
    color_t     held_top;                   // byte shown outside scan-out
    int         line_idx;                   // display lines since frame start

    function automatic string test_name(input int id);
        case (id)
            1:       return "after_reset";
            2:       return "bpp8_line";
            3:       return "bpp4_line";
            4:       return "bpp1_attr_line";
            5:       return "h_repeat_1";
            6:       return "h_repeat_3";
            7:       return "v_repeat_2";
            8:       return "end_of_frame";
            default: return "idle";
        endcase
    endfunction

    function automatic int words_per_group(input bpp_depth_t bpp);
        if (bpp == BPP_1_ATTR) return 1;
        if (bpp == BPP_4)      return 2;
        return 4;                           // 8 bpp, spare code too
    endfunction

    // colour index of pixel p (0..7) of the group starting at word base
    function automatic color_t ref_index(input bpp_depth_t bpp, input int base, input int p);
        word_t  w;
        color_t c;
        case (bpp)
            BPP_1_ATTR: begin
                w = ram_i[base % RAM_WORDS];
                c = w[7-p] ? {4'h0, w[11:8]} : {4'h0, w[15:12]};   // fg : bg
            end
            BPP_4: begin
                w = ram_i[(base + p / 4) % RAM_WORDS];
                c = {4'h0, w[15-4*(p%4) -: 4]};
            end
            default: begin
                w = ram_i[(base + p / 2) % RAM_WORDS];
                c = (p % 2 == 0) ? w[15:8] : w[7:0];              // high byte first
            end
        endcase
        return c;
    endfunction

    // sample mid cycle, inputs and output both settled
    always @(negedge clk) begin
        int     k;
        int     row_start;
        color_t exp_c;
        if (reset_i) begin
            scan_begin    = H_SCANOUT_BEGIN;
            scan_end      = H_SCANOUT_BEGIN;
            held_top      = '0;             // shifter cleared by reset
            line_idx      = 0;
            error_count_o = 0;
            check_count_o = 0;
        end else begin
            row_start = int'(pf_start_addr_i)
                      + (line_idx / (int'(pf_v_repeat_i) + 1)) * int'(pf_line_len_i);
            if (mem_fetch_i && h_count_i > scan_begin && h_count_i <= scan_end) begin
                k     = (int'(h_count_i) - int'(scan_begin) - 1) / (int'(pf_h_repeat_i) + 1);
                exp_c = ref_index(pf_bpp_i, row_start + (k / 8) * words_per_group(pf_bpp_i),
                                  k % 8) ^ pf_colorbase_i;
            end else begin
                exp_c = held_top ^ pf_colorbase_i;
            end
            check_count_o++;
            if (pf_color_index_i !== exp_c) begin
                error_count_o++;
                $display("FAIL %s: line %0d h %0d expected %02h actual %02h",
                         test_name(test_id_i), line_idx, h_count_i, exp_c, pf_color_index_i);
            end
            if (!mem_fetch_i && vram_sel_i) begin   // no reads on lines without fetch
                error_count_o++;
                $display("FAIL %s: vram_sel_o h %0d expected 0 actual 1",
                         test_name(test_id_i), h_count_i);
            end

            if (mem_fetch_i && h_count_i == scan_end) held_top = border_color_i;  // window closes
            if (end_of_line_i) begin
                scan_begin = H_SCANOUT_BEGIN + vid_left_i;  // next line's window
                scan_end   = H_SCANOUT_BEGIN + vid_right_i;
                line_idx++;
            end
            if (end_of_frame_i) line_idx = 0;
        end
    end

endmodule

/* verification/tb_video_playfield.sv */
module tb_video_playfield import pf_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_WORDS      = 4096;
    localparam int LINE_LEN       = 400;    // h counts per scanline
    localparam int FETCH_LEAD     = 32;     // fetch start ahead of scan-out start
    localparam int TOTAL_LINES    = 29;
    localparam int TIMEOUT_CYCLES = TOTAL_LINES * LINE_LEN * 12 / 10;

    logic       clk;
    logic       reset;
    hres_t      h_count;
    logic       mem_fetch, mem_fetch_start, end_of_line, end_of_frame;
    color_t     border_color, pf_colorbase, pf_color_index;
    hres_t      vid_left, vid_right;
    addr_t      pf_start_addr, vram_addr;
    word_t      pf_line_len, vram_data;
    bpp_depth_t pf_bpp;
    logic [1:0] pf_h_repeat, pf_v_repeat;
    logic       vram_sel;
    word_t      vram [RAM_WORDS];
    integer     seed;
    int         test_id, cycles, error_count, check_count;

    video_playfield video_playfield_i (
        .clk (clk), .reset_i (reset), .h_count_i (h_count), .mem_fetch_i (mem_fetch),
        .mem_fetch_start_i (mem_fetch_start), .end_of_line_i (end_of_line),
        .end_of_frame_i (end_of_frame), .border_color_i (border_color),
        .vid_left_i (vid_left), .vid_right_i (vid_right), .pf_start_addr_i (pf_start_addr),
        .pf_line_len_i (pf_line_len), .pf_colorbase_i (pf_colorbase), .pf_bpp_i (pf_bpp),
        .pf_h_repeat_i (pf_h_repeat), .pf_v_repeat_i (pf_v_repeat), .vram_sel_o (vram_sel),
        .vram_addr_o (vram_addr), .vram_data_i (vram_data), .pf_color_index_o (pf_color_index)
    );

    pf_checker #(.RAM_WORDS (RAM_WORDS)) pf_checker_i (
        .clk (clk), .reset_i (reset), .test_id_i (test_id), .h_count_i (h_count),
        .mem_fetch_i (mem_fetch), .end_of_line_i (end_of_line), .end_of_frame_i (end_of_frame),
        .border_color_i (border_color), .vid_left_i (vid_left), .vid_right_i (vid_right),
        .pf_start_addr_i (pf_start_addr), .pf_line_len_i (pf_line_len),
        .pf_colorbase_i (pf_colorbase), .pf_bpp_i (pf_bpp), .pf_h_repeat_i (pf_h_repeat),
        .pf_v_repeat_i (pf_v_repeat), .vram_sel_i (vram_sel), .pf_color_index_i (pf_color_index),
        .ram_i (vram), .error_count_o (error_count), .check_count_o (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    // video RAM, word at last cycle's address
    always @(posedge clk) begin
        if (vram_sel) vram_data <= vram[int'(vram_addr) % RAM_WORDS];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // one scanline of video timing, fetch lines get a fetch start and a window
    task automatic run_line(input logic fetch, input logic frame_end);
        int s;
        s = int'(H_SCANOUT_BEGIN) + int'(vid_left);
        for (int h = 0; h < LINE_LEN; h++) begin
            @(posedge clk);
            h_count         <= hres_t'(h);
            mem_fetch       <= fetch;
            mem_fetch_start <= fetch && (h == s - FETCH_LEAD);
            end_of_line     <= (h == LINE_LEN - 1);
            end_of_frame    <= frame_end && (h == LINE_LEN - 1);
        end
    endtask

    // new settings, a blank line that ends the frame, then display lines
    task automatic run_frame(input int id, input bpp_depth_t bpp, input int h_rep,
                             input int v_rep, input int len, input int start, input int cb,
                             input int border, input int left, input int right,
                             input int lines);
        test_id       <= id;
        pf_bpp        <= bpp;
        pf_h_repeat   <= 2'(h_rep);
        pf_v_repeat   <= 2'(v_rep);
        pf_line_len   <= word_t'(len);
        pf_start_addr <= addr_t'(start);
        pf_colorbase  <= color_t'(cb);
        border_color  <= color_t'(border);
        vid_left      <= hres_t'(left);
        vid_right     <= hres_t'(right);
        run_line(1'b0, 1'b1);
        for (int l = 0; l < lines; l++) run_line(1'b1, 1'b0);
    endtask

    initial begin
        seed = 32'h50bf;
        for (int a = 0; a < RAM_WORDS; a++) vram[a] = word_t'($random(seed));
        reset = 1'b1;
        cycles = 0;
        test_id = 0;
        h_count = '0;
        mem_fetch = 1'b0;
        mem_fetch_start = 1'b0;
        end_of_line = 1'b0;
        end_of_frame = 1'b0;
        border_color = 8'h3c;
        pf_colorbase = 8'h5a;
        vid_left = 11'd8;
        vid_right = 11'd200;
        pf_start_addr = '0;
        pf_line_len = '0;
        pf_bpp = BPP_8;
        pf_h_repeat = 2'd0;
        pf_v_repeat = 2'd0;
        vram_data = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_id <= 1;
        run_line(1'b0, 1'b0);               // output must stay at the colourbase
        run_frame(2, BPP_8,      0, 0, 64, 'h100, 'h5a, 'h3c, 8, 200, 2);
        run_frame(3, BPP_4,      0, 0, 48, 'h300, 'h00, 'h0f, 8, 200, 2);
        run_frame(4, BPP_1_ATTR, 0, 0, 32, 'h500, 'h81, 'h22, 8, 200, 2);
        run_frame(5, BPP_8,      1, 0, 80, 'h700, 'h0c, 'h91, 16, 232, 2);
        run_frame(6, BPP_4,      3, 0, 40, 'h900, 'h6e, 'h47, 4, 236, 2);
        run_frame(7, BPP_1_ATTR, 0, 2, 40, 'hb00, 'h13, 'he8, 8, 200, 7);
        run_frame(8, BPP_1_ATTR, 0, 2, 40, 'hb00, 'h13, 'he8, 8, 200, 4);  // rows start over
        repeat (2) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
